/* hw/cache_pkg.sv */
// cache package
// sizes, encodings and bus records shared by the queue, the scheduler and the pipe
package cache_pkg;

    localparam int NUM_TQ_ENTRY    = 4;
    localparam int ADDR_W          = 16;
    localparam int NUM_SETS        = 16;
    localparam int NUM_WORDS_IN_CL = 4;

    // byte address fields
    localparam int LSB_WORD_OFFSET = 2;
    localparam int MSB_WORD_OFFSET = 3;
    localparam int LSB_SET         = 4;
    localparam int MSB_SET         = 7;
    localparam int LSB_TAG         = 8;
    localparam int MSB_TAG         = 15;

    typedef logic [31:0]                        t_word;
    typedef t_word [NUM_WORDS_IN_CL-1:0]        t_cl;    // 128 bit line, word 0 at lsb
    typedef logic [MSB_TAG:LSB_SET]             t_cl_address;
    typedef logic [MSB_SET:LSB_SET]             t_set;
    typedef logic [MSB_TAG:LSB_TAG]             t_tag;
    typedef logic [1:0]                         t_word_offset;
    typedef logic [4:0]                         t_reg_id;
    typedef logic [$clog2(NUM_TQ_ENTRY)-1:0]    t_tq_id;
    typedef logic [2:0]                         t_credit_cnt;
    typedef logic [ADDR_W-1:0]                  t_address;

    typedef enum logic {RD_OP, WR_OP} t_opcode;
    typedef enum logic [1:0] {NO_LU, RD_LU, WR_LU, FILL_LU} t_lu_op;
    typedef enum logic {HIT, MISS} t_lu_result;
    typedef enum logic [2:0] {
        S_IDLE, S_LU_CORE, S_MB_WAIT_FILL, S_MB_FILL_READY, S_ERROR
    } t_tq_state;

    //------------------------------------------------------------
    // bus records
    //------------------------------------------------------------
    typedef struct packed {
        logic     valid;
        t_opcode  opcode;
        t_address address;
        t_word    data;
        t_reg_id  reg_id;
    } t_core_req;

    typedef struct packed {
        logic     valid;
        t_address address;
        t_word    data;
        t_reg_id  reg_id;
    } t_core_rsp;

    typedef struct packed {
        logic     valid;
        t_lu_op   lu_op;
        t_address address;
        t_word    data;
        t_cl      cl_data;
        t_tq_id   tq_id;
        t_reg_id  reg_id;
        logic     rd_indication;
    } t_lu_req;

    typedef struct packed {
        logic       valid;
        t_lu_op     lu_op;
        t_address   address;
        t_word      data;
        t_cl        cl_data;
        t_tq_id     tq_id;
        t_reg_id    reg_id;
        logic       rd_indication;
        t_lu_result lu_result;
    } t_lu_rsp;

    typedef struct packed {
        logic        valid;
        t_tq_id      tq_id;
        t_cl_address cl_address;
    } t_fm_rd_req;

    typedef struct packed {
        logic   valid;
        t_tq_id tq_id;
        t_cl    data;
    } t_fm_rd_rsp;

    typedef struct packed {
        logic     valid;
        t_address address;
        t_word    data;
    } t_fm_wr_req;

    typedef struct packed {
        t_tq_state    state;
        t_cl_address  cl_address;
        t_word_offset word_offset;
        logic         rd_indication;
        t_reg_id      reg_id;
        t_cl          mb_data;
    } t_tq_view;

    // lowest set bit, 0 when none
    function automatic t_tq_id first_idx(input logic [NUM_TQ_ENTRY-1:0] vec);
        first_idx = '0;
        for (int i = NUM_TQ_ENTRY - 1; i >= 0; i--) begin
            if (vec[i]) first_idx = t_tq_id'(i);
        end
    endfunction

    // core read to a line still held in this entry's merge buffer
    function automatic logic mb_rd_match(input t_tq_view v, input t_core_req r);
        mb_rd_match = r.valid && (r.opcode == RD_OP) &&
                      (r.address[MSB_TAG:LSB_SET] == v.cl_address) &&
                      ((v.state == S_MB_WAIT_FILL) || (v.state == S_MB_FILL_READY));
    endfunction

endpackage

/* hw/tq_entry.sv */
// transaction queue entry
// tracks one core request from lookup through miss, fill merge and fill lookup
module tq_entry (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 alloc,
    input  cache_pkg::t_core_req core_req,
    input  logic                 mb_rd_hit,
    input  logic                 lu_done,
    input  logic                 lu_miss,
    input  logic                 fill_valid,
    input  cache_pkg::t_cl       fill_line,
    input  logic                 fill_grant,
    output cache_pkg::t_tq_view  view,
    output logic                 goes_idle
);
    import cache_pkg::*;

    t_tq_state    state;
    t_tq_state    next_state;
    t_cl_address  cl_address;
    t_word_offset word_offset;
    t_reg_id      reg_id;
    logic         rd_indication;
    t_cl          mb_data;
    logic [NUM_WORDS_IN_CL-1:0] modified;   // words written by the core
    logic         stray;

    // events that make no sense in the current state
    assign stray = ((lu_done || lu_miss) && (state != S_LU_CORE)) ||
                   (fill_valid && (state != S_MB_WAIT_FILL)) ||
                   (fill_grant && (state != S_MB_FILL_READY));

    always_comb begin
        next_state = state;
        unique case (state)
            S_IDLE:          if (alloc) next_state = S_LU_CORE;
            S_LU_CORE: begin
                if (lu_done) next_state = S_IDLE;
                else if (lu_miss) next_state = S_MB_WAIT_FILL;
            end
            S_MB_WAIT_FILL:  if (fill_valid) next_state = S_MB_FILL_READY;
            S_MB_FILL_READY: if (fill_grant) next_state = S_IDLE;
            default:         next_state = S_ERROR;   // sticky
        endcase
        if (stray) next_state = S_ERROR;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    //------------------------------------------------------------
    // request record and merge buffer
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (alloc) begin
            cl_address    <= core_req.address[MSB_TAG:LSB_SET];
            word_offset   <= core_req.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET];
            reg_id        <= core_req.reg_id;
            rd_indication <= (core_req.opcode == RD_OP);
            modified      <= '0;
            if (core_req.opcode == WR_OP) begin
                mb_data[core_req.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET]] <= core_req.data;
                modified[core_req.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET]] <= 1'b1;
            end
        end else if (mb_rd_hit) begin
            // read merged into this entry, answered by the fill lookup
            rd_indication <= 1'b1;
            word_offset   <= core_req.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET];
            reg_id        <= core_req.reg_id;
        end
        if (fill_valid && (state == S_MB_WAIT_FILL)) begin
            for (int w = 0; w < NUM_WORDS_IN_CL; w++) begin
                if (!modified[w]) mb_data[w] <= fill_line[w];   // core data wins
            end
        end
    end

    assign goes_idle = ((state == S_LU_CORE) && lu_done) ||
                       ((state == S_MB_FILL_READY) && fill_grant);

    assign view = '{state: state, cl_address: cl_address, word_offset: word_offset,
                    rd_indication: rd_indication, reg_id: reg_id, mb_data: mb_data};

    a_alloc_idle: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> state == S_IDLE);
    a_no_error: assert property (@(posedge clk) disable iff (!rst_n)
        state != S_ERROR);

endmodule

/* hw/tq_alloc.sv */
// queue allocator
// picks the free entry for each core request and returns credits to the core
module tq_alloc (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  cache_pkg::t_core_req                              core_req,
    input  cache_pkg::t_tq_view [cache_pkg::NUM_TQ_ENTRY-1:0] views,
    input  logic [cache_pkg::NUM_TQ_ENTRY-1:0]                goes_idle,
    output logic [cache_pkg::NUM_TQ_ENTRY-1:0]                alloc,
    output logic [cache_pkg::NUM_TQ_ENTRY-1:0]                mb_rd_hit,
    output cache_pkg::t_credit_cnt                            credit_return
);
    import cache_pkg::*;

    logic [NUM_TQ_ENTRY-1:0] free;
    logic                    any_mb_hit;
    logic                    mb_hit_q;    // credit of a merged read, one cycle late
    t_credit_cnt             core_credits;

    always_comb begin
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            free[i]      = (views[i].state == S_IDLE);
            mb_rd_hit[i] = mb_rd_match(views[i], core_req);
        end
    end

    assign any_mb_hit = |mb_rd_hit;

    always_comb begin
        alloc = '0;
        if (core_req.valid && !any_mb_hit && (|free)) alloc[first_idx(free)] = 1'b1;
    end

    always_comb begin
        credit_return = t_credit_cnt'(mb_hit_q);
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            credit_return = credit_return + t_credit_cnt'(goes_idle[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mb_hit_q     <= 1'b0;
            core_credits <= t_credit_cnt'(NUM_TQ_ENTRY);
        end else begin
            mb_hit_q     <= any_mb_hit;
            core_credits <= core_credits - t_credit_cnt'(core_req.valid) + credit_return;
        end
    end

    // the core spends a credit per request
    a_credit: assert property (@(posedge clk) disable iff (!rst_n)
        core_req.valid |-> core_credits != '0);

endmodule

/* hw/tq_sched.sv */
// queue scheduler
// muxes core and fill lookups into the pipe and routes pipe and far memory results
module tq_sched (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  cache_pkg::t_core_req                              core_req,
    input  cache_pkg::t_tq_view [cache_pkg::NUM_TQ_ENTRY-1:0] views,
    input  cache_pkg::t_lu_rsp                                lu_rsp,
    input  cache_pkg::t_fm_rd_rsp                             fm_rd_rsp,
    output cache_pkg::t_lu_req                                lu_req,
    output logic [cache_pkg::NUM_TQ_ENTRY-1:0]                lu_done,
    output logic [cache_pkg::NUM_TQ_ENTRY-1:0]                lu_miss,
    output logic [cache_pkg::NUM_TQ_ENTRY-1:0]                fill_valid,
    output cache_pkg::t_cl                                    fill_line,
    output logic [cache_pkg::NUM_TQ_ENTRY-1:0]                fill_grant,
    output cache_pkg::t_core_rsp                              core_rsp
);
    import cache_pkg::*;

    logic [NUM_TQ_ENTRY-1:0] free;
    logic [NUM_TQ_ENTRY-1:0] fill_rdy;
    logic                    any_mb_hit;
    t_tq_id                  fill_id;
    logic                    core_lu;     // core lookup result in pipe

    always_comb begin
        any_mb_hit = 1'b0;
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            free[i]     = (views[i].state == S_IDLE);
            fill_rdy[i] = (views[i].state == S_MB_FILL_READY);
            any_mb_hit  = any_mb_hit || mb_rd_match(views[i], core_req);
        end
    end

    assign fill_id = first_idx(fill_rdy);   // lowest entry wins

    //------------------------------------------------------------
    // lookup mux, core first
    //------------------------------------------------------------
    always_comb begin
        lu_req = '0;
        if (core_req.valid) begin
            lu_req.valid         = 1'b1;
            lu_req.lu_op         = any_mb_hit ? NO_LU :     // cancelled, merged in entry
                                   (core_req.opcode == WR_OP) ? WR_LU : RD_LU;
            lu_req.address       = core_req.address;
            lu_req.data          = core_req.data;
            lu_req.tq_id         = first_idx(free);
            lu_req.reg_id        = core_req.reg_id;
            lu_req.rd_indication = (core_req.opcode == RD_OP);
        end else if (|fill_rdy) begin
            lu_req.valid         = 1'b1;
            lu_req.lu_op         = FILL_LU;
            lu_req.address       = {views[fill_id].cl_address, views[fill_id].word_offset, 2'b00};
            lu_req.cl_data       = views[fill_id].mb_data;
            lu_req.tq_id         = fill_id;
            lu_req.reg_id        = views[fill_id].reg_id;
            lu_req.rd_indication = views[fill_id].rd_indication;
        end
    end

    always_comb begin
        fill_grant = '0;
        if (!core_req.valid && (|fill_rdy)) fill_grant[fill_id] = 1'b1;
    end

    //------------------------------------------------------------
    // response decode
    //------------------------------------------------------------
    assign core_lu = lu_rsp.valid && ((lu_rsp.lu_op == RD_LU) || (lu_rsp.lu_op == WR_LU));

    always_comb begin
        for (int i = 0; i < NUM_TQ_ENTRY; i++) begin
            lu_done[i]    = core_lu && (lu_rsp.tq_id == t_tq_id'(i)) && (lu_rsp.lu_result == HIT);
            lu_miss[i]    = core_lu && (lu_rsp.tq_id == t_tq_id'(i)) && (lu_rsp.lu_result == MISS);
            fill_valid[i] = fm_rd_rsp.valid && (fm_rd_rsp.tq_id == t_tq_id'(i));
        end
    end

    assign fill_line = fm_rd_rsp.data;

    assign core_rsp.valid   = lu_rsp.valid &&
                              (((lu_rsp.lu_op == RD_LU) && (lu_rsp.lu_result == HIT)) ||
                               ((lu_rsp.lu_op == FILL_LU) && lu_rsp.rd_indication));
    assign core_rsp.address = lu_rsp.address;
    assign core_rsp.data    = lu_rsp.cl_data[lu_rsp.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET]];
    assign core_rsp.reg_id  = lu_rsp.reg_id;

    // far memory answers only entries waiting for their line
    a_fill_target: assert property (@(posedge clk) disable iff (!rst_n)
        fm_rd_rsp.valid |-> views[fm_rd_rsp.tq_id].state == S_MB_WAIT_FILL);

endmodule

/* hw/cache_pipe.sv */
// cache lookup pipe
// three stages over a direct-mapped tag and data array, write-through to far memory
module cache_pipe (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::t_lu_req    lu_req,
    output cache_pkg::t_lu_rsp    lu_rsp,
    output cache_pkg::t_fm_rd_req fm_rd_req,
    output cache_pkg::t_fm_wr_req fm_wr_req
);
    import cache_pkg::*;

    t_tag  tag_arr  [NUM_SETS];
    t_cl   data_arr [NUM_SETS];
    logic [NUM_SETS-1:0] valid_arr;

    t_lu_req s1;        // registered request
    t_lu_req s2;        // request with array read
    t_tag    s2_tag;
    logic    s2_vld;
    t_cl     s2_line;
    t_set    s1_set;
    t_set    s2_set;
    logic    hit;
    logic    core_lu;

    assign s1_set = s1.address[MSB_SET:LSB_SET];
    assign s2_set = s2.address[MSB_SET:LSB_SET];

    //------------------------------------------------------------
    // stage 1 and 2
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1 <= '0;
            s2 <= '0;
        end else begin
            s1 <= lu_req;
            s2 <= s1;
        end
    end

    always_ff @(posedge clk) begin
        s2_tag  <= tag_arr[s1_set];
        s2_vld  <= valid_arr[s1_set];
        s2_line <= data_arr[s1_set];
    end

    //------------------------------------------------------------
    // stage 3, compare and update
    //------------------------------------------------------------
    assign hit     = s2_vld && (s2_tag == s2.address[MSB_TAG:LSB_TAG]);
    assign core_lu = s2.valid && ((s2.lu_op == RD_LU) || (s2.lu_op == WR_LU));

    always_ff @(posedge clk) begin
        if (s2.valid && (s2.lu_op == WR_LU) && hit) begin
            data_arr[s2_set][s2.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET]] <= s2.data;
        end
        if (s2.valid && (s2.lu_op == FILL_LU)) begin
            data_arr[s2_set] <= s2.cl_data;      // line already merged in the queue
            tag_arr[s2_set]  <= s2.address[MSB_TAG:LSB_TAG];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_arr <= '0;
        end else if (s2.valid && (s2.lu_op == FILL_LU)) begin
            valid_arr[s2_set] <= 1'b1;
        end
    end

    assign lu_rsp.valid         = s2.valid;
    assign lu_rsp.lu_op         = s2.lu_op;
    assign lu_rsp.address       = s2.address;
    assign lu_rsp.data          = s2.data;
    assign lu_rsp.cl_data       = (s2.lu_op == FILL_LU) ? s2.cl_data : s2_line;
    assign lu_rsp.tq_id         = s2.tq_id;
    assign lu_rsp.reg_id        = s2.reg_id;
    assign lu_rsp.rd_indication = s2.rd_indication;
    assign lu_rsp.lu_result     = hit ? HIT : MISS;

    // line fetch on any core miss
    assign fm_rd_req.valid      = core_lu && !hit;
    assign fm_rd_req.tq_id      = s2.tq_id;
    assign fm_rd_req.cl_address = s2.address[MSB_TAG:LSB_SET];

    // every write goes through
    assign fm_wr_req.valid   = s2.valid && (s2.lu_op == WR_LU);
    assign fm_wr_req.address = s2.address;
    assign fm_wr_req.data    = s2.data;

endmodule

/* hw/cache_top.sv */
// data cache front end
// allocator, queue entries, scheduler and lookup pipe
module cache_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::t_core_req  core_req,
    input  cache_pkg::t_fm_rd_rsp fm_rd_rsp,
    output cache_pkg::t_core_rsp  core_rsp,
    output cache_pkg::t_credit_cnt credit_return,
    output cache_pkg::t_fm_rd_req fm_rd_req,
    output cache_pkg::t_fm_wr_req fm_wr_req
);
    import cache_pkg::*;

    t_tq_view [NUM_TQ_ENTRY-1:0] views;
    logic [NUM_TQ_ENTRY-1:0] goes_idle;
    logic [NUM_TQ_ENTRY-1:0] alloc;
    logic [NUM_TQ_ENTRY-1:0] mb_rd_hit;
    logic [NUM_TQ_ENTRY-1:0] lu_done;
    logic [NUM_TQ_ENTRY-1:0] lu_miss;
    logic [NUM_TQ_ENTRY-1:0] fill_valid;
    logic [NUM_TQ_ENTRY-1:0] fill_grant;
    t_cl                     fill_line;
    t_lu_req                 lu_req;
    t_lu_rsp                 lu_rsp;

    tq_alloc i_tq_alloc (
        .clk, .rst_n, .core_req, .views, .goes_idle,
        .alloc, .mb_rd_hit, .credit_return
    );

    for (genvar g = 0; g < NUM_TQ_ENTRY; g++) begin : g_tq
        tq_entry i_tq_entry (
            .clk, .rst_n,
            .alloc      (alloc[g]),
            .core_req,
            .mb_rd_hit  (mb_rd_hit[g]),
            .lu_done    (lu_done[g]),
            .lu_miss    (lu_miss[g]),
            .fill_valid (fill_valid[g]),
            .fill_line,
            .fill_grant (fill_grant[g]),
            .view       (views[g]),
            .goes_idle  (goes_idle[g])
        );
    end

    tq_sched i_tq_sched (
        .clk, .rst_n, .core_req, .views, .lu_rsp, .fm_rd_rsp,
        .lu_req, .lu_done, .lu_miss, .fill_valid, .fill_line, .fill_grant, .core_rsp
    );

    cache_pipe i_cache_pipe (
        .clk, .rst_n, .lu_req, .lu_rsp, .fm_rd_req, .fm_wr_req
    );

endmodule

/* tests/tb_cache_top.sv */
// testbench for the data cache front end
// far memory model, core credit tracking and directed tests
module tb_cache_top;
    import cache_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    t_core_req   core_req;
    t_fm_rd_rsp  fm_rd_rsp;
    t_core_rsp   core_rsp;
    t_credit_cnt credit_return;
    t_fm_rd_req  fm_rd_req;
    t_fm_wr_req  fm_wr_req;

    int       seed = 87929;
    int       cycle = 0;
    int       credits = NUM_TQ_ENTRY;   // credits held by the core
    int       credit_sum = 0;
    int       fm_rd_cnt = 0;
    int       fm_wr_cnt = 0;
    int       fm_delay = 4;             // far memory read latency in cycles
    int       errors = 0;
    int       checks = 0;
    int       tests = 0;
    int       last_req_cycle = 0;
    t_address last_wr_addr;
    t_word    last_wr_data;

    t_word      mem [1 << 14];          // one word per word address
    t_core_rsp  rsp_q[$];
    int         rsp_cyc_q[$];
    t_fm_rd_req rd_q[$];                // open far memory reads
    int         rd_due_q[$];

    cache_top i_cache_top (
        .clk, .rst_n, .core_req, .fm_rd_rsp,
        .core_rsp, .credit_return, .fm_rd_req, .fm_wr_req
    );

    always #4 clk = ~clk;

    //------------------------------------------------------------
    // far memory model and output monitor
    //------------------------------------------------------------
    function automatic t_word model_word(input t_address addr);
        return mem[addr[ADDR_W-1:2]];
    endfunction

    function automatic t_cl line_of(input t_cl_address cl);
        t_cl line;
        for (int w = 0; w < NUM_WORDS_IN_CL; w++) begin
            line[w] = mem[{cl, 2'(w)}];
        end
        return line;
    endfunction

    always @(posedge clk) begin
        cycle      = cycle + 1;
        credits    = credits + int'(credit_return);
        credit_sum = credit_sum + int'(credit_return);
        if (credits > NUM_TQ_ENTRY) begin
            $display("core credit count rose to %0d at time %0t", credits, $time);
            errors++;
        end
        if (core_rsp.valid) begin
            rsp_q.push_back(core_rsp);
            rsp_cyc_q.push_back(cycle);
        end
        if (fm_wr_req.valid) begin
            mem[fm_wr_req.address[ADDR_W-1:2]] = fm_wr_req.data;
            last_wr_addr = fm_wr_req.address;
            last_wr_data = fm_wr_req.data;
            fm_wr_cnt++;
        end
        if (fm_rd_req.valid) begin
            rd_q.push_back(fm_rd_req);
            rd_due_q.push_back(cycle + fm_delay);
            fm_rd_cnt++;
        end
    end

    // answers in request order, one line per cycle at most
    always @(negedge clk) begin
        fm_rd_rsp = '0;
        if ((rd_q.size() > 0) && (rd_due_q[0] <= cycle)) begin
            fm_rd_rsp.valid = 1'b1;
            fm_rd_rsp.tq_id = rd_q[0].tq_id;
            fm_rd_rsp.data  = line_of(rd_q[0].cl_address);
            rd_q.delete(0);
            rd_due_q.delete(0);
        end
    end

    //------------------------------------------------------------
    // helpers
    //------------------------------------------------------------
    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic issue(input t_opcode op, input t_address addr, input t_word data,
                         input t_reg_id reg_id);
        int waited;
        waited = 0;
        @(negedge clk);
        while ((credits == 0) && (waited < WAIT_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
        if (credits == 0) begin
            $display("no credit came back for a request at time %0t", $time);
            errors++;
        end else begin
            core_req.valid   = 1'b1;
            core_req.opcode  = op;
            core_req.address = addr;
            core_req.data    = data;
            core_req.reg_id  = reg_id;
            last_req_cycle   = cycle + 1;   // posedge that takes it
            credits--;
            @(negedge clk);
            core_req = '0;
        end
    endtask

    task automatic expect_rsp(input t_address addr, input t_reg_id reg_id, input t_word data,
                              output int at_cycle);
        t_core_rsp rsp;
        int        waited;
        waited   = 0;
        at_cycle = 0;
        while ((rsp_q.size() == 0) && (waited < WAIT_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
        if (rsp_q.size() == 0) begin
            $display("no core response for reg %0d by time %0t", reg_id, $time);
            errors++;
        end else begin
            rsp      = rsp_q.pop_front();
            at_cycle = rsp_cyc_q.pop_front();
            check_eq(32'(rsp.address), 32'(addr), "core_rsp address");
            check_eq(32'(rsp.reg_id), 32'(reg_id), "core_rsp reg_id");
            check_eq(rsp.data, data, "core_rsp data");
        end
    endtask

    task automatic wait_credits(input int target, input int limit);
        int waited;
        waited = 0;
        while ((credits != target) && (waited < limit)) begin
            @(negedge clk);
            waited++;
        end
        if (credits != target) begin
            $display("core credits stuck at %0d instead of %0d at time %0t",
                     credits, target, $time);
            errors++;
        end
    endtask

    task automatic wait_fm_rd(input int target);
        int waited;
        waited = 0;
        while ((fm_rd_cnt < target) && (waited < WAIT_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
        if (fm_rd_cnt < target) begin
            $display("far memory read request never came by time %0t", $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        check_eq(32'(rsp_q.size()), 32'd0, "unexpected core responses");
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_start);
    endtask

    //------------------------------------------------------------
    // directed tests
    //------------------------------------------------------------
    task automatic test_reset_idle();
        int err_start;
        err_start = errors;
        repeat (10) @(negedge clk);   // core idle
        check_eq(32'(rsp_q.size()), 32'd0, "core responses after reset");
        check_eq(32'(credit_sum), 32'd0, "credits returned after reset");
        check_eq(32'(fm_rd_cnt), 32'd0, "far memory reads after reset");
        check_eq(32'(fm_wr_cnt), 32'd0, "far memory writes after reset");
        check_eq(32'(credits), 32'(NUM_TQ_ENTRY), "core credits after reset");
        finish_test("reset_idle", err_start);
    endtask

    task automatic test_read_miss_hit();
        int err_start;
        int at;
        err_start = errors;
        fm_delay  = 6;
        issue(RD_OP, 16'h1234, '0, 5'd3);
        expect_rsp(16'h1234, 5'd3, model_word(16'h1234), at);
        issue(RD_OP, 16'h1234, '0, 5'd4);
        expect_rsp(16'h1234, 5'd4, model_word(16'h1234), at);
        check_eq(32'(at), 32'(last_req_cycle + 2), "read hit response cycle");
        wait_credits(NUM_TQ_ENTRY, WAIT_LIMIT);
        finish_test("read_miss_hit", err_start);
    endtask

    task automatic test_write_miss_fill();
        int       err_start;
        int       wr_start;
        int       at;
        t_address addr;
        err_start = errors;
        wr_start  = fm_wr_cnt;
        fm_delay  = 5;
        issue(WR_OP, 16'h4558, 32'hcafe_0123, 5'd0);
        wait_credits(NUM_TQ_ENTRY, WAIT_LIMIT);    // back after the fill lookup
        check_eq(32'(fm_wr_cnt - wr_start), 32'd1, "far memory writes");
        check_eq(32'(last_wr_addr), 32'h4558, "write-through address");
        check_eq(last_wr_data, 32'hcafe_0123, "write-through data");
        repeat (3) @(negedge clk);   // fill lookup leaves the pipe
        for (int w = 0; w < NUM_WORDS_IN_CL; w++) begin
            addr = 16'h4550 + t_address'(4 * w);
            issue(RD_OP, addr, '0, t_reg_id'(20 + w));
            expect_rsp(addr, t_reg_id'(20 + w), (w == 2) ? 32'hcafe_0123 : model_word(addr), at);
        end
        finish_test("write_miss_fill", err_start);
    endtask

    task automatic test_mb_read_hit();
        int err_start;
        int rd_start;
        int at;
        err_start = errors;
        rd_start  = fm_rd_cnt;
        fm_delay  = 30;
        issue(RD_OP, 16'h7870, '0, 5'd7);
        wait_fm_rd(rd_start + 1);
        issue(RD_OP, 16'h7874, '0, 5'd8);
        wait_credits(NUM_TQ_ENTRY - 1, 4);
        check_eq(32'(rd_q.size()), 32'd1, "open far memory reads at early credit");
        // merged read takes over the entry's pending response
        expect_rsp(16'h7874, 5'd8, model_word(16'h7874), at);
        wait_credits(NUM_TQ_ENTRY, WAIT_LIMIT);
        check_eq(32'(fm_rd_cnt - rd_start), 32'd1, "far memory reads for one line");
        repeat (2) @(negedge clk);
        issue(RD_OP, 16'h7870, '0, 5'd7);   // first word now from the array
        expect_rsp(16'h7870, 5'd7, model_word(16'h7870), at);
        finish_test("mb_read_hit", err_start);
    endtask

    task automatic test_credit_drain();
        t_address addrs [NUM_TQ_ENTRY];
        int       err_start;
        int       sum_start;
        int       at;
        err_start = errors;
        sum_start = credit_sum;
        fm_delay  = 40;
        addrs     = '{16'h9a80, 16'h3b94, 16'hc4a8, 16'h5dbc};   // sets 8 to 11
        for (int k = 0; k < NUM_TQ_ENTRY; k++) begin
            issue(RD_OP, addrs[k], '0, t_reg_id'(10 + k));
        end
        check_eq(32'(credits), 32'd0, "core credits after four misses");
        for (int k = 0; k < NUM_TQ_ENTRY; k++) begin
            expect_rsp(addrs[k], t_reg_id'(10 + k), model_word(addrs[k]), at);
        end
        wait_credits(NUM_TQ_ENTRY, WAIT_LIMIT);
        check_eq(32'(credit_sum - sum_start), 32'(NUM_TQ_ENTRY), "sum of credit_return");
        finish_test("credit_drain", err_start);
    endtask

    task automatic test_write_hit_read();
        int err_start;
        int rd_start;
        int wr_start;
        int at;
        err_start = errors;
        rd_start  = fm_rd_cnt;
        wr_start  = fm_wr_cnt;
        issue(WR_OP, 16'h1238, 32'h5a5a_0f0f, 5'd0);   // line cached by the first test
        wait_credits(NUM_TQ_ENTRY, WAIT_LIMIT);
        check_eq(32'(fm_rd_cnt - rd_start), 32'd0, "far memory reads for a write hit");
        check_eq(32'(fm_wr_cnt - wr_start), 32'd1, "far memory writes for a write hit");
        repeat (2) @(negedge clk);
        issue(RD_OP, 16'h1238, '0, 5'd9);
        expect_rsp(16'h1238, 5'd9, 32'h5a5a_0f0f, at);
        finish_test("write_hit_read", err_start);
    endtask

    //------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------
    initial begin
        core_req  = '0;
        fm_rd_rsp = '0;
        for (int i = 0; i < (1 << 14); i++) begin
            mem[i] = $random(seed);
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        test_reset_idle();
        test_read_miss_hit();
        test_write_miss_fill();
        test_mb_read_hit();
        test_credit_drain();
        test_write_hit_read();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #100000;
        $display("simulation ran too long, a test never finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* cache_top.f */
hw/cache_pkg.sv
hw/tq_entry.sv
hw/tq_alloc.sv
hw/tq_sched.sv
hw/cache_pipe.sv
hw/cache_top.sv
tests/tb_cache_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_cache_top
FILELIST  := cache_top.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
